//--- hdl/rs_settings.svh
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// reservation station geometry
`define RS_DEPTH 8
`define RS_TAG_W 3

// architectural state
`define ARCH_REGS 8
`define ARCH_REG_W 3

// data path
`define WORD_W 32
`define IMM_W 16

// cycles from issue_ack to the mul result
`define MUL_LATENCY 4

`endif

//--- hdl/rs_types_pkg.sv
`include "rs_settings.svh"

package rs_types_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`ARCH_REG_W-1:0] arch_reg_t;
    typedef logic [`RS_TAG_W-1:0]   rs_tag_t;   // entry index, doubles as rename tag
    typedef logic [`IMM_W-1:0]      imm_t;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_xor = 3'd2,
        op_mul = 3'd3,
        op_li  = 3'd4    // rd = zero-extended imm
    } alu_op_t;

endpackage

//--- hdl/rs_fsm_pkg.sv
package rs_fsm_pkg;

    // four-phase req/ack controller
    typedef enum logic [1:0] {
        hs_idle    = 2'd0,
        hs_req     = 2'd1,
        hs_release = 2'd2
    } hs_state_t;

    typedef enum logic [1:0] {
        ex_idle  = 2'd0,
        ex_ack   = 2'd1,
        ex_busy  = 2'd2,   // mul in flight
        ex_bcast = 2'd3
    } exec_state_t;

endpackage

//--- hdl/dispatch_unit.sv
`include "rs_settings.svh"

module dispatch_unit (
    input  logic                  rs_on,
    input  logic                  rst,
    input  logic                  instr_req,
    input  rs_types_pkg::alu_op_t instr_op,
    input  rs_types_pkg::arch_reg_t instr_rd,
    input  rs_types_pkg::arch_reg_t instr_rs1,
    input  rs_types_pkg::arch_reg_t instr_rs2,
    input  rs_types_pkg::imm_t    instr_imm,
    output logic                  instr_ack,
    output logic                  disp_req,
    output rs_types_pkg::alu_op_t disp_op,
    output rs_types_pkg::arch_reg_t disp_rd,
    output rs_types_pkg::word_t   disp_src1_val,
    output rs_types_pkg::rs_tag_t disp_src1_tag,
    output logic                  disp_src1_rdy,
    output rs_types_pkg::word_t   disp_src2_val,
    output rs_types_pkg::rs_tag_t disp_src2_tag,
    output logic                  disp_src2_rdy,
    output rs_types_pkg::imm_t    disp_imm,
    input  logic                  disp_ack,
    input  rs_types_pkg::rs_tag_t alloc_tag,
    input  logic                  cdb_valid,
    input  rs_types_pkg::rs_tag_t cdb_tag,
    input  rs_types_pkg::word_t   cdb_value
);
    import rs_types_pkg::*;
    import rs_fsm_pkg::*;

    word_t                regs [`ARCH_REGS];
    rs_tag_t              ttag [`ARCH_REGS];
    logic [`ARCH_REGS-1:0] pend;
    hs_state_t            st;
    logic                 in1_fwd, in2_fwd;

    // result landing in the intake cycle
    assign in1_fwd = cdb_valid && pend[instr_rs1] && (ttag[instr_rs1] == cdb_tag);
    assign in2_fwd = cdb_valid && pend[instr_rs2] && (ttag[instr_rs2] == cdb_tag);

    // held dispatch fields
    always_ff @(posedge rs_on) begin
        if (st == hs_idle && instr_req) begin
            disp_op       <= instr_op;
            disp_rd       <= instr_rd;
            disp_imm      <= instr_imm;
            disp_src1_val <= in1_fwd ? cdb_value : regs[instr_rs1];
            disp_src1_tag <= ttag[instr_rs1];
            disp_src1_rdy <= !pend[instr_rs1] || in1_fwd;
            disp_src2_val <= in2_fwd ? cdb_value : regs[instr_rs2];
            disp_src2_tag <= ttag[instr_rs2];
            disp_src2_rdy <= !pend[instr_rs2] || in2_fwd;
        end else if (st == hs_req && cdb_valid) begin
            if (!disp_src1_rdy && disp_src1_tag == cdb_tag) begin
                disp_src1_val <= cdb_value;
                disp_src1_rdy <= 1'b1;
            end
            if (!disp_src2_rdy && disp_src2_tag == cdb_tag) begin
                disp_src2_val <= cdb_value;
                disp_src2_rdy <= 1'b1;
            end
        end
    end

    always_ff @(posedge rs_on or posedge rst) begin
        if (rst) begin
            st        <= hs_idle;
            disp_req  <= 1'b0;
            instr_ack <= 1'b0;
            pend      <= '0;
            for (int r = 0; r < `ARCH_REGS; r++) begin
                regs[r] <= '0;
                ttag[r] <= '0;
            end
        end else begin
            if (cdb_valid) begin
                for (int r = 0; r < `ARCH_REGS; r++) begin
                    if (pend[r] && ttag[r] == cdb_tag) begin
                        regs[r] <= cdb_value;
                        pend[r] <= 1'b0;
                    end
                end
            end
            case (st)
                hs_idle: if (instr_req) begin
                    disp_req <= 1'b1;
                    st       <= hs_req;
                end
                hs_req: if (disp_ack) begin
                    disp_req        <= 1'b0;
                    instr_ack       <= 1'b1;
                    pend[disp_rd]   <= 1'b1;   // rename overrides a same-cycle clear
                    ttag[disp_rd]   <= alloc_tag;
                    st              <= hs_release;
                end
                hs_release: if (!instr_req && !disp_ack) begin
                    instr_ack <= 1'b0;
                    st        <= hs_idle;
                end
                default: st <= hs_idle;
            endcase
        end
    end

    // request held until the station answers
    assert property (@(posedge rs_on) disable iff (rst)
        disp_req && !disp_ack |=> disp_req);

endmodule

//--- hdl/reservation_station.sv
`include "rs_settings.svh"

module reservation_station (
    input  logic                    rs_on,
    input  logic                    rst,
    input  logic                    disp_req,
    input  rs_types_pkg::alu_op_t   disp_op,
    input  rs_types_pkg::arch_reg_t disp_rd,
    input  rs_types_pkg::word_t     disp_src1_val,
    input  rs_types_pkg::rs_tag_t   disp_src1_tag,
    input  logic                    disp_src1_rdy,
    input  rs_types_pkg::word_t     disp_src2_val,
    input  rs_types_pkg::rs_tag_t   disp_src2_tag,
    input  logic                    disp_src2_rdy,
    input  rs_types_pkg::imm_t      disp_imm,
    output logic                    disp_ack,
    output rs_types_pkg::rs_tag_t   alloc_tag,
    input  logic                    cdb_valid,
    input  rs_types_pkg::rs_tag_t   cdb_tag,
    input  rs_types_pkg::word_t     cdb_value,
    output logic                    issue_req,
    output rs_types_pkg::alu_op_t   issue_op,
    output rs_types_pkg::word_t     issue_a,
    output rs_types_pkg::word_t     issue_b,
    output rs_types_pkg::imm_t      issue_imm,
    output rs_types_pkg::rs_tag_t   issue_tag,
    input  logic                    issue_ack,
    output logic                    retire_valid,
    output rs_types_pkg::arch_reg_t retire_rd,
    output rs_types_pkg::word_t     retire_value
);
    import rs_types_pkg::*;
    import rs_fsm_pkg::*;

    alu_op_t   e_op     [`RS_DEPTH];
    arch_reg_t e_rd     [`RS_DEPTH];
    imm_t      e_imm    [`RS_DEPTH];
    word_t     e_val1   [`RS_DEPTH];
    word_t     e_val2   [`RS_DEPTH];
    rs_tag_t   e_tag1   [`RS_DEPTH];
    rs_tag_t   e_tag2   [`RS_DEPTH];
    word_t     e_result [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] rdy1, rdy2, issued, done;

    rs_tag_t             head, tail, sel_idx;
    logic [`RS_TAG_W:0]  count;
    hs_state_t           iss_state;
    logic                full, alloc, retire, sel_found, issue_start;
    logic                src1_hit, src2_hit;

    assign full        = (count == `RS_DEPTH);
    assign alloc       = disp_req && !disp_ack && !full;
    assign retire      = (count != 0) && done[head];
    assign issue_start = (iss_state == hs_idle) && sel_found;
    // wakeup of the entry being written this cycle
    assign src1_hit    = cdb_valid && !disp_src1_rdy && (disp_src1_tag == cdb_tag);
    assign src2_hit    = cdb_valid && !disp_src2_rdy && (disp_src2_tag == cdb_tag);

    // oldest ready, not yet issued
    always_comb begin
        rs_tag_t idx;
        sel_found = 1'b0;
        sel_idx   = head;
        for (int k = 0; k < `RS_DEPTH; k++) begin
            idx = head + rs_tag_t'(k);
            if (!sel_found && k < count && !issued[idx] &&
                (e_op[idx] == op_li || (rdy1[idx] && rdy2[idx]))) begin
                sel_found = 1'b1;
                sel_idx   = idx;
            end
        end
    end

    always_ff @(posedge rs_on) begin
        if (cdb_valid) begin
            e_result[cdb_tag] <= cdb_value;
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (!rdy1[i] && e_tag1[i] == cdb_tag) e_val1[i] <= cdb_value;
                if (!rdy2[i] && e_tag2[i] == cdb_tag) e_val2[i] <= cdb_value;
            end
        end
        if (alloc) begin   // after wakeup so stale tags lose
            e_op[tail]   <= disp_op;
            e_rd[tail]   <= disp_rd;
            e_imm[tail]  <= disp_imm;
            e_tag1[tail] <= disp_src1_tag;
            e_tag2[tail] <= disp_src2_tag;
            e_val1[tail] <= src1_hit ? cdb_value : disp_src1_val;
            e_val2[tail] <= src2_hit ? cdb_value : disp_src2_val;
        end
        if (issue_start) begin
            issue_op  <= e_op[sel_idx];
            issue_a   <= e_val1[sel_idx];
            issue_b   <= e_val2[sel_idx];
            issue_imm <= e_imm[sel_idx];
            issue_tag <= sel_idx;
        end
        if (retire) begin
            retire_rd    <= e_rd[head];
            retire_value <= e_result[head];
        end
    end

    always_ff @(posedge rs_on or posedge rst) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            disp_ack     <= 1'b0;
            alloc_tag    <= '0;
            iss_state    <= hs_idle;
            issue_req    <= 1'b0;
            retire_valid <= 1'b0;
            rdy1         <= '0;
            rdy2         <= '0;
            issued       <= '0;
            done         <= '0;
        end else begin
            retire_valid <= retire;
            if (retire) head <= head + 1'b1;
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase

            if (cdb_valid) begin
                done[cdb_tag] <= 1'b1;
                for (int i = 0; i < `RS_DEPTH; i++) begin
                    if (e_tag1[i] == cdb_tag) rdy1[i] <= 1'b1;
                    if (e_tag2[i] == cdb_tag) rdy2[i] <= 1'b1;
                end
            end

            if (alloc) begin
                tail         <= tail + 1'b1;
                alloc_tag    <= tail;
                disp_ack     <= 1'b1;
                rdy1[tail]   <= disp_src1_rdy || src1_hit;
                rdy2[tail]   <= disp_src2_rdy || src2_hit;
                issued[tail] <= 1'b0;
                done[tail]   <= 1'b0;
            end else if (!disp_req) begin
                disp_ack <= 1'b0;
            end

            case (iss_state)
                hs_idle: if (sel_found) begin
                    issue_req <= 1'b1;
                    iss_state <= hs_req;
                end
                hs_req: if (issue_ack) begin
                    issue_req         <= 1'b0;
                    issued[issue_tag] <= 1'b1;
                    iss_state         <= hs_release;
                end
                hs_release: if (!issue_ack) iss_state <= hs_idle;
                default: iss_state <= hs_idle;
            endcase
        end
    end

    // count bounded and pointers consistent, so nothing lands past full
    assert property (@(posedge rs_on) disable iff (rst)
        count <= `RS_DEPTH && tail == rs_tag_t'(head + count));

    // ack rises only under a live request
    assert property (@(posedge rs_on) disable iff (rst)
        $rose(disp_ack) |-> disp_req);

endmodule

//--- hdl/exec_unit.sv
`include "rs_settings.svh"

module exec_unit (
    input  logic                  rs_on,
    input  logic                  rst,
    input  logic                  issue_req,
    input  rs_types_pkg::alu_op_t issue_op,
    input  rs_types_pkg::word_t   issue_a,
    input  rs_types_pkg::word_t   issue_b,
    input  rs_types_pkg::imm_t    issue_imm,
    input  rs_types_pkg::rs_tag_t issue_tag,
    output logic                  issue_ack,
    output logic                  cdb_valid,
    output rs_types_pkg::rs_tag_t cdb_tag,
    output rs_types_pkg::word_t   cdb_value
);
    import rs_types_pkg::*;
    import rs_fsm_pkg::*;

    localparam int CNT_W = $clog2(`MUL_LATENCY);

    exec_state_t      ex_state;
    logic [CNT_W-1:0] mul_cnt;
    logic             is_mul;
    logic             accept;
    word_t            alu_out;

    assign accept = (ex_state == ex_idle) && issue_req && !issue_ack;

    always_comb begin
        case (issue_op)
            op_add:  alu_out = issue_a + issue_b;
            op_sub:  alu_out = issue_a - issue_b;
            op_xor:  alu_out = issue_a ^ issue_b;
            op_mul:  alu_out = issue_a * issue_b;   // low word only
            default: alu_out = {{(`WORD_W-`IMM_W){1'b0}}, issue_imm};
        endcase
    end

    // result and tag held until broadcast
    always_ff @(posedge rs_on) begin
        if (accept) begin
            cdb_value <= alu_out;
            cdb_tag   <= issue_tag;
        end
    end

    always_ff @(posedge rs_on or posedge rst) begin
        if (rst) begin
            ex_state  <= ex_idle;
            issue_ack <= 1'b0;
            cdb_valid <= 1'b0;
            mul_cnt   <= '0;
            is_mul    <= 1'b0;
        end else begin
            if (issue_ack && !issue_req) issue_ack <= 1'b0;
            cdb_valid <= 1'b0;
            case (ex_state)
                ex_idle: if (accept) begin
                    issue_ack <= 1'b1;
                    is_mul    <= (issue_op == op_mul);
                    ex_state  <= ex_ack;
                end
                ex_ack: if (is_mul) begin
                    mul_cnt  <= CNT_W'(`MUL_LATENCY - 2);
                    ex_state <= ex_busy;
                end else begin
                    cdb_valid <= 1'b1;
                    ex_state  <= ex_bcast;
                end
                ex_busy: if (mul_cnt == 0) begin
                    cdb_valid <= 1'b1;
                    ex_state  <= ex_bcast;
                end else begin
                    mul_cnt <= mul_cnt - 1'b1;
                end
                ex_bcast: ex_state <= ex_idle;
                default:  ex_state <= ex_idle;
            endcase
        end
    end

    assert property (@(posedge rs_on) disable iff (rst) cdb_valid |=> !cdb_valid);

    assert property (@(posedge rs_on) disable iff (rst)
        $rose(issue_ack) |-> $past(ex_state) == ex_idle);

endmodule

//--- hdl/ooo_core_top.sv
module ooo_core_top (
    input  logic                    rs_on,
    input  logic                    rst,
    input  logic                    instr_req,
    input  rs_types_pkg::alu_op_t   instr_op,
    input  rs_types_pkg::arch_reg_t instr_rd,
    input  rs_types_pkg::arch_reg_t instr_rs1,
    input  rs_types_pkg::arch_reg_t instr_rs2,
    input  rs_types_pkg::imm_t      instr_imm,
    output logic                    instr_ack,
    output logic                    retire_valid,
    output rs_types_pkg::arch_reg_t retire_rd,
    output rs_types_pkg::word_t     retire_value
);
    import rs_types_pkg::*;

    // dispatch to station
    logic      disp_req, disp_ack, disp_src1_rdy, disp_src2_rdy;
    alu_op_t   disp_op;
    arch_reg_t disp_rd;
    word_t     disp_src1_val, disp_src2_val;
    rs_tag_t   disp_src1_tag, disp_src2_tag, alloc_tag;
    imm_t      disp_imm;

    // issue and result bus
    logic      issue_req, issue_ack, cdb_valid;
    alu_op_t   issue_op;
    word_t     issue_a, issue_b, cdb_value;
    imm_t      issue_imm;
    rs_tag_t   issue_tag, cdb_tag;

    dispatch_unit u_dispatch (.*);

    reservation_station u_rs (.*);

    exec_unit u_exec (.*);

endmodule

//--- verif/ooo_core_checker.sv
`include "rs_settings.svh"

module ooo_core_checker (
    input  logic                    rs_on,
    input  logic                    rst,
    input  logic                    instr_req,
    input  rs_types_pkg::alu_op_t   instr_op,
    input  rs_types_pkg::arch_reg_t instr_rd,
    input  rs_types_pkg::arch_reg_t instr_rs1,
    input  rs_types_pkg::arch_reg_t instr_rs2,
    input  rs_types_pkg::imm_t      instr_imm,
    input  logic                    instr_ack,
    input  logic                    retire_valid,
    input  rs_types_pkg::arch_reg_t retire_rd,
    input  rs_types_pkg::word_t     retire_value,
    output int                      err_count,
    output int                      acc_count,
    output int                      ret_count,
    output int                      pending,
    output int                      max_outstanding
);
    import rs_types_pkg::*;

    word_t     arch [`ARCH_REGS];   // in-order register file
    arch_reg_t exp_rd [$];
    word_t     exp_val [$];
    logic      prev_req;
    logic      prev_ack;

    initial begin
        err_count       = 0;
        acc_count       = 0;
        ret_count       = 0;
        pending         = 0;
        max_outstanding = 0;
        prev_req        = 1'b0;
        prev_ack        = 1'b0;
        for (int r = 0; r < `ARCH_REGS; r++) arch[r] = '0;
    end

    // sequential semantics, 32-bit wrap
    function automatic word_t model_result(input alu_op_t op, input word_t a, input word_t b,
                                           input imm_t imm);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_xor:  return a ^ b;
            op_mul:  return a * b;
            default: return word_t'(imm);   // zero-extended
        endcase
    endfunction

    always @(posedge rs_on) begin
        word_t exp_v;
        arch_reg_t exp_r;
        if (!rst) begin
            if (prev_ack && !instr_ack && prev_req) begin
                $display("at %0t instr_ack fell while instr_req was still high", $time);
                err_count++;
            end
            if (instr_ack && !prev_ack) begin   // accepted instruction
                exp_v = model_result(instr_op, arch[instr_rs1], arch[instr_rs2], instr_imm);
                arch[instr_rd] = exp_v;
                exp_rd.push_back(instr_rd);
                exp_val.push_back(exp_v);
                acc_count++;
                if (acc_count - ret_count > max_outstanding)
                    max_outstanding = acc_count - ret_count;
                if (acc_count - ret_count > `RS_DEPTH) begin
                    $display("at %0t instr_ack rose with more than %0d instructions outstanding",
                             $time, `RS_DEPTH);
                    err_count++;
                end
            end
            if (retire_valid) begin
                ret_count++;
                if (exp_rd.size() == 0) begin
                    $display("at %0t a retire appeared with no instruction outstanding", $time);
                    err_count++;
                end else begin
                    exp_r = exp_rd.pop_front();
                    exp_v = exp_val.pop_front();
                    if (retire_rd !== exp_r) begin
                        $display("ERROR t=%0t retire_rd expected %0d actual %0d",
                                 $time, exp_r, retire_rd);
                        err_count++;
                    end
                    if (retire_value !== exp_v) begin
                        $display("ERROR t=%0t retire_value expected %08h actual %08h",
                                 $time, exp_v, retire_value);
                        err_count++;
                    end
                end
            end
        end
        prev_req = instr_req;
        prev_ack = instr_ack;
        pending  <= exp_rd.size();
    end

endmodule

//--- verif/ooo_core_tb.sv
`include "rs_settings.svh"

module ooo_core_tb;
    import rs_types_pkg::*;

    localparam int     N_LI       = 40;
    localparam int     N_CHAIN    = 60;
    localparam int     N_MUL      = 88;
    localparam int     N_MIX      = 200;
    localparam int     PERIOD     = 40;
    localparam int     RST_CYCLES = 8;
    localparam longint TIMEOUT    = (N_LI + N_CHAIN + `ARCH_REGS + N_MUL + N_MIX)
                                    * (`MUL_LATENCY + 12) * PERIOD + RST_CYCLES * PERIOD;

    logic      rs_on, rst, instr_req, instr_ack, retire_valid;
    alu_op_t   instr_op;
    arch_reg_t instr_rd, instr_rs1, instr_rs2, retire_rd;
    imm_t      instr_imm;
    word_t     retire_value;
    int        err_count, acc_count, ret_count, pending, max_outstanding;
    int        tb_errors = 0;
    int        err_mark = 0;
    integer    seed = 35531;

    ooo_core_top dut (.*);

    ooo_core_checker chk (.*);

    initial begin
        rs_on = 1'b0;
        forever #(PERIOD / 2) rs_on = ~rs_on;
    end

    initial begin   // watchdog
        #(TIMEOUT);
        $display("watchdog expired: the run timed out before all instructions retired");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic int unsigned draw(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // one four-phase transfer on the instruction port, from the current edge
    task automatic send_instr(input alu_op_t op, input arch_reg_t rd, input arch_reg_t rs1,
                              input arch_reg_t rs2, input imm_t imm);
        instr_req <= 1'b1;
        instr_op  <= op;
        instr_rd  <= rd;
        instr_rs1 <= rs1;
        instr_rs2 <= rs2;
        instr_imm <= imm;
        do @(posedge rs_on); while (!instr_ack);
        instr_req <= 1'b0;
        do @(posedge rs_on); while (instr_ack);
    endtask

    task automatic end_test(input string name);
        int quiet;
        int errs;
        quiet = 0;
        while (quiet < 40) begin   // queue empty, retire port idle
            @(posedge rs_on);
            if (retire_valid || pending != 0) quiet = 0;
            else quiet++;
        end
        if (ret_count != acc_count) begin
            $display("ERROR t=%0t retire count expected %0d actual %0d",
                     $time, acc_count, ret_count);
            tb_errors++;
        end
        errs     = err_count + tb_errors - err_mark;
        err_mark = err_count + tb_errors;
        $display("test %-16s %s (%0d errors)", name, (errs == 0) ? "ok" : "failed", errs);
    endtask

    initial begin
        arch_reg_t prev_rd;
        arch_reg_t next_rd;
        rst       = 1'b1;
        instr_req = 1'b0;
        instr_op  = op_add;
        instr_rd  = '0;
        instr_rs1 = '0;
        instr_rs2 = '0;
        instr_imm = '0;
        repeat (RST_CYCLES) @(posedge rs_on);
        rst <= 1'b0;

        for (int i = 0; i < N_LI; i++)
            send_instr(op_li, arch_reg_t'(draw(8)), '0, '0, imm_t'($random(seed)));
        end_test("load-immediate");

        // three registers only, so most sources wait on a tag
        for (int i = 0; i < N_CHAIN; i++)
            send_instr(alu_op_t'(draw(3)), arch_reg_t'(draw(3)), arch_reg_t'(draw(3)),
                       arch_reg_t'(draw(3)), imm_t'($random(seed)));
        end_test("dependent chains");

        // odd seeds keep long products nonzero
        for (int r = 0; r < `ARCH_REGS; r++)
            send_instr(op_li, arch_reg_t'(r), '0, '0, imm_t'($random(seed)) | imm_t'(1));
        prev_rd = '0;
        for (int i = 0; i < N_MUL; i++) begin
            next_rd = arch_reg_t'(draw(8));
            // each mul waits on the one before, so the station backs up
            send_instr(op_mul, next_rd, prev_rd, arch_reg_t'(draw(8)), imm_t'($random(seed)));
            prev_rd = next_rd;
        end
        if (max_outstanding != `RS_DEPTH) begin
            $display("ERROR t=%0t peak outstanding expected %0d actual %0d",
                     $time, `RS_DEPTH, max_outstanding);
            tb_errors++;
        end
        end_test("multiply pressure");

        for (int i = 0; i < N_MIX; i++)
            send_instr(alu_op_t'(draw(5)), arch_reg_t'(draw(8)), arch_reg_t'(draw(8)),
                       arch_reg_t'(draw(8)), imm_t'($random(seed)));
        end_test("random mix");

        $display("accepted %0d retired %0d errors %0d",
                 acc_count, ret_count, err_count + tb_errors);
        if (err_count + tb_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+hdl
hdl/rs_types_pkg.sv
hdl/rs_fsm_pkg.sv
hdl/dispatch_unit.sv
hdl/reservation_station.sv
hdl/exec_unit.sv
hdl/ooo_core_top.sv
verif/ooo_core_checker.sv
verif/ooo_core_tb.sv
